// ==== filelist.f ====
hw/xbar_pkg.sv
hw/xbar_addr_decoder.sv
hw/xbar_initiator_demux.sv
hw/xbar_target_arbiter.sv
hw/xbar_top.sv
bench/tb_target_mem.sv
bench/xbar_tb.sv

// ==== bench/xbar_tb.sv ====
/*
  Testbench for the single-word crossbar, 3 initiators, 3 targets.
  Each initiator runs directed and random reads and writes in its own
  address slice (bits 9:8 carry the initiator number), so a per-target
  memory model predicts every response. A monitor counts handshakes
  and checks that every target request belongs on that target.
*/
module xbar_tb;
  import xbar_pkg::*;

  localparam int NumInit  = 3;
  localparam int NumTgt   = 3;
  localparam int NumRules = 4;
  localparam int NumRand  = 60;
  localparam int NumHam   = 20;
  localparam int TxnPerIni = 5 + NumRand + NumHam;
  localparam longint Timeout = longint'(NumInit * TxnPerIni) * 40 * 100;
  localparam bit [NumInit-1:0][NumTgt-1:0] Conn = {3'b110, 3'b111, 3'b111};

  logic                        clk_i;
  logic                        reset_i;
  logic [NumInit-1:0]          ini_req_valid;
  logic [NumInit-1:0]          ini_req_ready_o;
  xbar_req_t [NumInit-1:0]     ini_req;
  logic [NumInit-1:0]          ini_rsp_valid_o;
  logic [NumInit-1:0]          ini_rsp_ready;
  xbar_rsp_t [NumInit-1:0]     ini_rsp_o;
  logic [NumTgt-1:0]           tgt_req_valid_o, tgt_req_ready, tgt_rsp_valid, tgt_rsp_ready_o;
  xbar_req_t [NumTgt-1:0]      tgt_req_o;
  xbar_rsp_t [NumTgt-1:0]      tgt_rsp;
  addr_rule_t [NumRules-1:0]   addr_map;
  logic [NumInit-1:0]          en_default;
  tgt_idx_t [NumInit-1:0]      default_idx;

  logic [31:0] model [NumTgt][256];
  logic [31:0] rnd [NumInit];
  int          n_req [NumInit];
  int          n_rsp [NumInit];
  int          checks;
  int          errors;

  xbar_top #(
    .NumInit      ( NumInit  ),
    .NumTgt       ( NumTgt   ),
    .NumRules     ( NumRules ),
    .Connectivity ( Conn     )
  ) UUT (
    .clk_i, .reset_i,
    .ini_req_valid_i ( ini_req_valid ), .ini_req_ready_o, .ini_req_i ( ini_req ),
    .ini_rsp_valid_o, .ini_rsp_ready_i ( ini_rsp_ready ), .ini_rsp_o,
    .tgt_req_valid_o, .tgt_req_ready_i ( tgt_req_ready ), .tgt_req_o,
    .tgt_rsp_valid_i ( tgt_rsp_valid ), .tgt_rsp_ready_o, .tgt_rsp_i ( tgt_rsp ),
    .addr_map_i ( addr_map ), .en_default_i ( en_default ), .default_idx_i ( default_idx )
  );

  for (genvar t = 0; t < NumTgt; t++) begin : gen_mem
    tb_target_mem #(
      .TgtId ( t ),
      .Seed  ( 32'hffca ^ (t * 32'h1357) )
    ) i_mem (
      .clk_i, .reset_i,
      .req_valid_i ( tgt_req_valid_o[t] ), .req_ready_o ( tgt_req_ready[t] ),
      .req_i ( tgt_req_o[t] ),
      .rsp_valid_o ( tgt_rsp_valid[t] ), .rsp_ready_i ( tgt_rsp_ready_o[t] ),
      .rsp_o ( tgt_rsp[t] )
    );
  end

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_rand(input int i, output logic [31:0] r);
    rnd[i] = xorshift(rnd[i]);
    r      = rnd[i];
  endtask

  // Expected route by rule priority, then default, then connectivity
  function automatic void route(input int ini, input logic [31:0] addr,
                                output int tgt, output bit err);
    bit hit;
    hit = 0;
    tgt = 0;
    err = 0;
    for (int r = 0; r < NumRules; r++) begin
      if (!hit && addr >= addr_map[r].start_addr && addr < addr_map[r].end_addr) begin
        hit = 1;
        tgt = addr_map[r].idx;
      end
    end
    if (!hit) begin
      if (en_default[ini]) tgt = default_idx[ini];
      else err = 1;
    end
    if (!err && (tgt >= NumTgt || !Conn[ini][tgt])) err = 1;
  endfunction

  task automatic do_txn(input int i, input bit we, input logic [31:0] addr,
                        input logic [31:0] data);
    int          tgt;
    bit          err;
    xbar_rsp_t   exp;
    logic [31:0] r;
    route(i, addr, tgt, err);
    exp = '0;
    if (err) exp.err = 1'b1;
    else if (we) model[tgt][addr[9:2]] = data;
    else exp.rdata = model[tgt][addr[9:2]];
    @(posedge clk_i);
    ini_req_valid[i] <= 1'b1;
    ini_req[i]       <= '{addr: addr, wdata: data, we: we};
    do @(posedge clk_i); while (!ini_req_ready_o[i]);
    next_rand(i, r);
    ini_req_valid[i] <= 1'b0;
    ini_rsp_ready[i] <= r[3];
    forever begin
      @(posedge clk_i);
      if (ini_rsp_valid_o[i] && ini_rsp_ready[i]) break;
      next_rand(i, r);
      ini_rsp_ready[i] <= r[3] | r[7];  // Mostly ready, sometimes stalls
    end
    checks++;
    assert (ini_rsp_o[i] === exp) else begin
      errors++;
      $display("Error at %0t: initiator %0d %s addr %h got err %b rdata %h, expected %b %h",
               $time, i, we ? "write" : "read", addr, ini_rsp_o[i].err,
               ini_rsp_o[i].rdata, exp.err, exp.rdata);
    end
    ini_rsp_ready[i] <= 1'b0;
  endtask

  // Regions 0 to 3 are mapped and region 4 only hits the default route
  function automatic logic [31:0] make_addr(input int i, input int region,
                                            input logic [5:0] word);
    logic [31:0] base;
    base = (region == 4) ? 32'h8000 : region * 32'h1000;
    return base | (i << 8) | (word << 2);
  endfunction

  task automatic run_initiator(input int i);
    logic [31:0] r, d;
    do_txn(i, 1'b1, make_addr(i, i == 2 ? 1 : 0, 6'd5), 32'hc0de_0000 + i);
    do_txn(i, 1'b0, make_addr(i, i == 2 ? 1 : 0, 6'd5), '0);
    do_txn(i, 1'b1, make_addr(i, 4, 6'd9), 32'hdef0_0000 + i);
    do_txn(i, 1'b0, make_addr(i, 4, 6'd9), '0);
    do_txn(i, 1'b0, make_addr(i, 0, 6'd1), '0);  // Disabled path for initiator 2
    for (int n = 0; n < NumRand + NumHam; n++) begin
      next_rand(i, r);
      next_rand(i, d);
      do_txn(i, r[0], make_addr(i, n < NumRand ? int'(r[15:8] % 5) : 1, r[21:16]), d);
    end
  endtask

  // Handshake counting and the routing watch
  always @(posedge clk_i) begin : monitor
    int tgt;
    bit err;
    if (!reset_i) begin
      for (int i = 0; i < NumInit; i++) begin
        if (ini_req_valid[i] && ini_req_ready_o[i]) n_req[i]++;
        if (ini_rsp_valid_o[i]) begin
          assert (n_rsp[i] < n_req[i]) else begin
            errors++;
            $display("Error at %0t: initiator %0d response without an open request",
                     $time, i);
          end
        end
        if (ini_rsp_valid_o[i] && ini_rsp_ready[i]) n_rsp[i]++;
      end
      // Bits 9:8 name the initiator, so each target request traces back
      for (int t = 0; t < NumTgt; t++) begin
        if (tgt_req_valid_o[t]) begin
          route(int'(tgt_req_o[t].addr[9:8]), tgt_req_o[t].addr, tgt, err);
          assert (!err && tgt == t) else begin
            errors++;
            $display("Error at %0t: target %0d got addr %h from initiator %0d",
                     $time, t, tgt_req_o[t].addr, tgt_req_o[t].addr[9:8]);
          end
        end
      end
    end
  end

  initial begin
    #(Timeout);
    $display("Watchdog expired before all transactions completed");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    reset_i       = 1'b1;
    ini_req_valid = '0;
    ini_req       = '0;
    ini_rsp_ready = '0;
    en_default    = 3'b001;           // Only initiator 0 has a default
    default_idx   = '0;
    default_idx[0] = tgt_idx_t'(1);
    addr_map[0]   = '{idx: 4'd0, start_addr: 32'h0000, end_addr: 32'h1000};
    addr_map[1]   = '{idx: 4'd1, start_addr: 32'h1000, end_addr: 32'h2000};
    addr_map[2]   = '{idx: 4'd2, start_addr: 32'h2000, end_addr: 32'h3000};
    addr_map[3]   = '{idx: 4'd1, start_addr: 32'h2000, end_addr: 32'h4000};
    checks = 0;
    errors = 0;
    for (int i = 0; i < NumInit; i++) begin
      rnd[i]   = 32'hffca ^ (i * 32'h9e37_79b9);
      n_req[i] = 0;
      n_rsp[i] = 0;
    end
    for (int t = 0; t < NumTgt; t++)
      for (int k = 0; k < 256; k++)
        model[t][k] = 32'h5a00_0000 ^ (t << 16) ^ (k * 32'h0101_0101);
    // Outputs stay quiet through reset and the cycles after it
    for (int c = 0; c < 18; c++) begin
      @(posedge clk_i);
      if (c == 15) reset_i <= 1'b0;  // Sixteenth reset edge
      @(negedge clk_i);
      checks++;
      assert (ini_rsp_valid_o == '0 && tgt_req_valid_o == '0) else begin
        errors++;
        $display("Error at %0t: valid output high around reset", $time);
      end
    end
    fork
      run_initiator(0);
      run_initiator(1);
      run_initiator(2);
    join
    repeat (4) @(posedge clk_i);
    for (int i = 0; i < NumInit; i++) begin
      checks++;
      assert (n_req[i] == TxnPerIni && n_rsp[i] == TxnPerIni) else begin
        errors++;
        $display("Error at %0t: initiator %0d made %0d requests and got %0d responses",
                 $time, i, n_req[i], n_rsp[i]);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/tb_target_mem.sv ====
/*
  Memory target model for the crossbar testbench.
  Accepts one request at a time with a random ready, then answers
  after a random delay of zero to three cycles and holds the
  response until it is taken. Word index is addr[9:2].
*/
module tb_target_mem
  import xbar_pkg::*;
#(
  parameter int unsigned TgtId = 0,
  parameter logic [31:0] Seed  = 32'hffca
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_valid_i,
  output logic             req_ready_o = 1'b0,
  input  xbar_req_t        req_i,
  output logic             rsp_valid_o = 1'b0,
  input  logic             rsp_ready_i,
  output xbar_rsp_t        rsp_o = '0
);

  logic [31:0] mem [256];
  logic [31:0] rnd;
  logic        busy;
  logic [1:0]  cnt;   // Remaining response delay

  function automatic logic [31:0] step_rng(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Start contents, must match the fill used by the testbench model
  initial begin
    for (int k = 0; k < 256; k++) begin
      mem[k] = 32'h5a00_0000 ^ (TgtId << 16) ^ (k * 32'h0101_0101);
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      rnd         <= Seed;
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      busy        <= 1'b0;
      cnt         <= '0;
    end else begin
      rnd <= step_rng(rnd);
      if (req_valid_i && req_ready_o) begin
        busy        <= 1'b1;
        req_ready_o <= 1'b0;
        cnt         <= rnd[1:0];
        rsp_o.err   <= 1'b0;
        rsp_o.rdata <= req_i.we ? '0 : mem[req_i.addr[9:2]];
        if (req_i.we) mem[req_i.addr[9:2]] <= req_i.wdata;
      end else if (busy && !rsp_valid_o) begin
        if (cnt == 0) rsp_valid_o <= 1'b1;
        else cnt <= cnt - 1'b1;
      end else if (rsp_valid_o && rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
        busy        <= 1'b0;
      end else if (!busy) begin
        req_ready_o <= rnd[4];  // About half the idle cycles
      end
    end
  end

endmodule

// ==== hw/xbar_top.sv ====
/*
  Fully connected single-word crossbar.
  One demux per initiator, one arbiter per target, and the
  initiator-by-target matrix of handshake wires between them.
  Paths cleared in Connectivity are tied off here and answered
  with an error by the initiator's own demux.
*/
module xbar_top
  import xbar_pkg::*;
#(
  parameter int unsigned                   NumInit      = 3,
  parameter int unsigned                   NumTgt       = 3,
  parameter int unsigned                   NumRules     = 4,
  parameter bit [NumInit-1:0][NumTgt-1:0]  Connectivity = '1
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Initiator ports
  input  logic [NumInit-1:0]        ini_req_valid_i,
  output logic [NumInit-1:0]        ini_req_ready_o,
  input  xbar_req_t [NumInit-1:0]   ini_req_i,
  output logic [NumInit-1:0]        ini_rsp_valid_o,
  input  logic [NumInit-1:0]        ini_rsp_ready_i,
  output xbar_rsp_t [NumInit-1:0]   ini_rsp_o,
  // Target ports
  output logic [NumTgt-1:0]         tgt_req_valid_o,
  input  logic [NumTgt-1:0]         tgt_req_ready_i,
  output xbar_req_t [NumTgt-1:0]    tgt_req_o,
  input  logic [NumTgt-1:0]         tgt_rsp_valid_i,
  output logic [NumTgt-1:0]         tgt_rsp_ready_o,
  input  xbar_rsp_t [NumTgt-1:0]    tgt_rsp_i,
  // Address map and defaults
  input  addr_rule_t [NumRules-1:0] addr_map_i,
  input  logic [NumInit-1:0]        en_default_i,
  input  tgt_idx_t [NumInit-1:0]    default_idx_i
);

  // Demux view, indexed [initiator][target]
  logic [NumInit-1:0][NumTgt-1:0] dm_req_valid, dm_req_ready;
  logic [NumInit-1:0][NumTgt-1:0] dm_rsp_valid, dm_rsp_ready;
  // Arbiter view, indexed [target][initiator]
  logic [NumTgt-1:0][NumInit-1:0] ar_req_valid, ar_req_ready;
  logic [NumTgt-1:0][NumInit-1:0] ar_rsp_valid, ar_rsp_ready;
  xbar_req_t [NumInit-1:0]        dm_req;   // Shared by all targets of a demux
  xbar_rsp_t [NumTgt-1:0]         ar_rsp;   // Shared by all demuxes

  for (genvar i = 0; i < NumInit; i++) begin : gen_demux
    xbar_initiator_demux #(
      .NumTgt   ( NumTgt          ),
      .NumRules ( NumRules        ),
      .ConnRow  ( Connectivity[i] )
    ) i_demux (
      .clk_i           ( clk_i              ),
      .reset_i         ( reset_i            ),
      .req_valid_i     ( ini_req_valid_i[i] ),
      .req_ready_o     ( ini_req_ready_o[i] ),
      .req_i           ( ini_req_i[i]       ),
      .rsp_valid_o     ( ini_rsp_valid_o[i] ),
      .rsp_ready_i     ( ini_rsp_ready_i[i] ),
      .rsp_o           ( ini_rsp_o[i]       ),
      .addr_map_i      ( addr_map_i         ),
      .en_default_i    ( en_default_i[i]    ),
      .default_idx_i   ( default_idx_i[i]   ),
      .tgt_req_valid_o ( dm_req_valid[i]    ),
      .tgt_req_ready_i ( dm_req_ready[i]    ),
      .tgt_req_o       ( dm_req[i]          ),
      .tgt_rsp_valid_i ( dm_rsp_valid[i]    ),
      .tgt_rsp_ready_o ( dm_rsp_ready[i]    ),
      .tgt_rsp_i       ( ar_rsp             )
    );
  end

  // Cross the matrix, disabled paths stay silent
  for (genvar i = 0; i < NumInit; i++) begin : gen_cross_ini
    for (genvar j = 0; j < NumTgt; j++) begin : gen_cross_tgt
      if (Connectivity[i][j]) begin : gen_path
        assign ar_req_valid[j][i] = dm_req_valid[i][j];
        assign dm_req_ready[i][j] = ar_req_ready[j][i];
        assign dm_rsp_valid[i][j] = ar_rsp_valid[j][i];
        assign ar_rsp_ready[j][i] = dm_rsp_ready[i][j];
      end else begin : gen_no_path
        assign ar_req_valid[j][i] = 1'b0;
        assign dm_req_ready[i][j] = 1'b0;
        assign dm_rsp_valid[i][j] = 1'b0;
        assign ar_rsp_ready[j][i] = 1'b0;
      end
    end
  end

  for (genvar j = 0; j < NumTgt; j++) begin : gen_arbiter
    xbar_target_arbiter #(
      .NumInit ( NumInit )
    ) i_arbiter (
      .clk_i           ( clk_i              ),
      .reset_i         ( reset_i            ),
      .ini_req_valid_i ( ar_req_valid[j]    ),
      .ini_req_ready_o ( ar_req_ready[j]    ),
      .ini_req_i       ( dm_req             ),
      .ini_rsp_valid_o ( ar_rsp_valid[j]    ),
      .ini_rsp_ready_i ( ar_rsp_ready[j]    ),
      .ini_rsp_o       ( ar_rsp[j]          ),
      .req_valid_o     ( tgt_req_valid_o[j] ),
      .req_ready_i     ( tgt_req_ready_i[j] ),
      .req_o           ( tgt_req_o[j]       ),
      .rsp_valid_i     ( tgt_rsp_valid_i[j] ),
      .rsp_ready_o     ( tgt_rsp_ready_o[j] ),
      .rsp_i           ( tgt_rsp_i[j]       )
    );
  end

endmodule

// ==== hw/xbar_target_arbiter.sv ====
/*
  Per-target arbitrating multiplexer.
  Picks one requesting demux round-robin, starting after the last
  winner, and locks onto it from the request handshake until the
  target's response handshake. The response goes to the owner only.
  The grant itself is combinational while unlocked.
*/
module xbar_target_arbiter
  import xbar_pkg::*;
#(
  parameter int unsigned NumInit = 3
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Demux side
  input  logic [NumInit-1:0]        ini_req_valid_i,
  output logic [NumInit-1:0]        ini_req_ready_o,
  input  xbar_req_t [NumInit-1:0]   ini_req_i,
  output logic [NumInit-1:0]        ini_rsp_valid_o,
  input  logic [NumInit-1:0]        ini_rsp_ready_i,
  output xbar_rsp_t                 ini_rsp_o,
  // Target side
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output xbar_req_t                 req_o,
  input  logic                      rsp_valid_i,
  output logic                      rsp_ready_o,
  input  xbar_rsp_t                 rsp_i
);

  localparam int unsigned IdxW = (NumInit > 1) ? $clog2(NumInit) : 1;

  typedef logic [IdxW-1:0] ini_idx_t;

  logic [NumInit-1:0] grant;
  logic               found;
  ini_idx_t           win;
  logic               lock_q;
  ini_idx_t           owner_q;   // Also the last winner for round-robin
  logic               req_fire;
  logic               rsp_fire;

  // Round-robin search, first candidate is the one after the last winner
  always_comb begin : rr_pick
    int cand;
    found = 1'b0;
    win   = owner_q;
    grant = '0;
    for (int k = 1; k <= NumInit; k++) begin
      cand = (int'(owner_q) + k) % NumInit;
      if (!found && ini_req_valid_i[cand]) begin
        found = 1'b1;
        win   = ini_idx_t'(cand);
      end
    end
    if (!lock_q && found) begin
      grant[win] = 1'b1;
    end
  end

  assign req_valid_o     = !lock_q && found;
  assign req_o           = ini_req_i[win];
  assign ini_req_ready_o = grant & {NumInit{req_ready_i}};

  // Response back to the owner only
  always_comb begin
    ini_rsp_valid_o = '0;
    for (int i = 0; i < NumInit; i++) begin
      if (owner_q == ini_idx_t'(i)) begin
        ini_rsp_valid_o[i] = lock_q && rsp_valid_i;
      end
    end
  end

  assign ini_rsp_o   = rsp_i;
  assign rsp_ready_o = lock_q && ini_rsp_ready_i[owner_q];

  assign req_fire = req_valid_o && req_ready_i;
  assign rsp_fire = rsp_valid_i && rsp_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q  <= 1'b0;
      owner_q <= ini_idx_t'(NumInit - 1);  // Initiator 0 gets first turn
    end else if (req_fire) begin
      lock_q  <= 1'b1;
      owner_q <= win;
    end else if (rsp_fire) begin
      lock_q  <= 1'b0;
    end
  end

  // Targets answer only what they were given
  a_rsp_when_locked: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> lock_q);

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant));

endmodule

// ==== hw/xbar_initiator_demux.sv ====
/*
  Per-initiator demultiplexer.
  Decodes the request address, hands the request to one target
  and keeps the port busy until that target's response is taken.
  Requests that fail to decode never leave this block: the built-in
  error responder answers them one cycle after the handshake.
  Only one transaction is open at any time.
*/
module xbar_initiator_demux
  import xbar_pkg::*;
#(
  parameter int unsigned     NumTgt   = 3,
  parameter int unsigned     NumRules = 4,
  parameter bit [NumTgt-1:0] ConnRow  = '1
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Initiator side
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  xbar_req_t                 req_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output xbar_rsp_t                 rsp_o,
  // Decode control
  input  addr_rule_t [NumRules-1:0] addr_map_i,
  input  logic                      en_default_i,
  input  tgt_idx_t                  default_idx_i,
  // Target side
  output logic [NumTgt-1:0]         tgt_req_valid_o,
  input  logic [NumTgt-1:0]         tgt_req_ready_i,
  output xbar_req_t                 tgt_req_o,
  input  logic [NumTgt-1:0]         tgt_rsp_valid_i,
  output logic [NumTgt-1:0]         tgt_rsp_ready_o,
  input  xbar_rsp_t [NumTgt-1:0]    tgt_rsp_i
);

  tgt_idx_t  dec_idx;
  logic      dec_err;
  logic      sel_ready;
  logic      open_valid;
  xbar_rsp_t open_rsp;
  logic      busy_q;    // Transaction open
  logic      err_q;     // Open transaction is answered locally
  tgt_idx_t  sel_q;     // Target holding the open transaction
  logic      req_fire;
  logic      rsp_fire;

  xbar_addr_decoder #(
    .NumTgt   ( NumTgt   ),
    .NumRules ( NumRules ),
    .ConnRow  ( ConnRow  )
  ) i_decoder (
    .addr_i        ( req_i.addr    ),
    .addr_map_i    ( addr_map_i    ),
    .en_default_i  ( en_default_i  ),
    .default_idx_i ( default_idx_i ),
    .idx_o         ( dec_idx       ),
    .dec_err_o     ( dec_err       )
  );

  // Request steering
  always_comb begin
    tgt_req_valid_o = '0;
    sel_ready       = 1'b0;
    for (int t = 0; t < NumTgt; t++) begin
      if (dec_idx == tgt_idx_t'(t)) begin
        tgt_req_valid_o[t] = req_valid_i && !busy_q && !dec_err;
        sel_ready          = tgt_req_ready_i[t];
      end
    end
  end

  assign tgt_req_o   = req_i;
  assign req_ready_o = !busy_q && (dec_err || sel_ready);  // Error path always accepts

  // Response steering from the open target
  always_comb begin
    tgt_rsp_ready_o = '0;
    open_valid      = 1'b0;
    open_rsp        = '0;
    for (int t = 0; t < NumTgt; t++) begin
      if (sel_q == tgt_idx_t'(t)) begin
        open_valid         = tgt_rsp_valid_i[t];
        open_rsp           = tgt_rsp_i[t];
        tgt_rsp_ready_o[t] = busy_q && !err_q && rsp_ready_i;
      end
    end
  end

  assign rsp_valid_o = busy_q && (err_q || open_valid);
  assign rsp_o       = err_q ? ERR_RSP : open_rsp;

  assign req_fire = req_valid_i && req_ready_o;
  assign rsp_fire = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      err_q  <= 1'b0;
      sel_q  <= '0;
    end else if (req_fire) begin
      busy_q <= 1'b1;
      err_q  <= dec_err;
      sel_q  <= dec_idx;
    end else if (rsp_fire) begin
      busy_q <= 1'b0;
    end
  end

  // The default route may not move under a waiting request
  a_default_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_valid_i && !req_ready_o) |=> ($stable(en_default_i) && $stable(default_idx_i)));

  a_one_target: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(tgt_req_valid_o));

endmodule

// ==== hw/xbar_addr_decoder.sv ====
/*
  Address decoder for one initiator port.
  Searches the rule map by priority, the lowest numbered hit wins.
  Without a hit the default target is taken when enabled.
  A miss, an index beyond the target count or a path switched
  off in the connectivity row all raise dec_err_o.
  Purely combinational.
*/
module xbar_addr_decoder
  import xbar_pkg::*;
#(
  parameter int unsigned          NumTgt   = 3,
  parameter int unsigned          NumRules = 4,
  parameter bit [NumTgt-1:0]      ConnRow  = '1   // Reachable targets of this initiator
) (
  input  logic [ADDR_W-1:0]       addr_i,
  input  addr_rule_t [NumRules-1:0] addr_map_i,
  input  logic                    en_default_i,
  input  tgt_idx_t                default_idx_i,
  output tgt_idx_t                idx_o,
  output logic                    dec_err_o
);

  logic     rule_found;
  tgt_idx_t rule_idx;
  tgt_idx_t sel_idx;
  logic     path_on;

  // Priority search over the rules
  always_comb begin
    rule_found = 1'b0;
    rule_idx   = '0;
    for (int r = 0; r < NumRules; r++) begin
      if (!rule_found && rule_hit(addr_map_i[r], addr_i)) begin
        rule_found = 1'b1;
        rule_idx   = addr_map_i[r].idx;
      end
    end
  end

  assign sel_idx = rule_found ? rule_idx : default_idx_i;

  // Index must name an existing target with its path enabled
  always_comb begin
    path_on = 1'b0;
    for (int t = 0; t < NumTgt; t++) begin
      if (sel_idx == tgt_idx_t'(t)) begin
        path_on = ConnRow[t];
      end
    end
  end

  assign dec_err_o = !(rule_found || en_default_i) || !path_on;
  assign idx_o     = dec_err_o ? '0 : sel_idx;

endmodule

// ==== hw/xbar_pkg.sv ====
/*
  Shared definitions for the single-word bus crossbar.
  Holds the bus widths, the request and response payloads,
  the address rule format and the target index type.
  Every crossbar module imports this package in its header.
*/
package xbar_pkg;

  // Bus widths
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;

  // Up to 15 targets, the top code is left for the error path
  localparam int unsigned TGT_IDX_W = 4;

  typedef logic [TGT_IDX_W-1:0] tgt_idx_t;

  // Request beat, one word read or write
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;     // High for a write
  } xbar_req_t;

  // Response beat
  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // Zero for writes and errors
    logic              err;
  } xbar_rsp_t;

  // Address rule, covers start_addr up to but not including end_addr
  typedef struct packed {
    tgt_idx_t          idx;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] end_addr;
  } addr_rule_t;

  // Response returned for decode errors and disabled paths
  localparam xbar_rsp_t ERR_RSP = '{rdata: '0, err: 1'b1};

  // True when the address falls inside the rule window
  function automatic logic rule_hit(
    input addr_rule_t        rule,
    input logic [ADDR_W-1:0] addr
  );
    return (addr >= rule.start_addr) && (addr < rule.end_addr);
  endfunction

endpackage
